// ==== test/adc_capture_properties.sv ====
// Deserializer assertions

`timescale 1ns/100ps

module adc_capture_properties (
  input logic                    ssi_clk,
  input logic                    rst_n,
  input logic                    cnv,
  input logic                    word_valid,
  input logic                    busy,
  input logic                    two_lane,
  input adc_pkg::capture_state_e state
);

  // Assertion failures so far that the testbench reads at the end
  int fail_count = 0;

  // A one-lane word takes twenty edges, so two valid pulses can never touch
  single_valid_pulse: assert property (
    @(posedge ssi_clk) disable iff (!rst_n)
    (word_valid && !two_lane) |=> !word_valid
  ) else begin
    $error("word_valid was high on two consecutive cycles in one-lane mode");
    fail_count++;
  end

  // Busy covers the whole conversion from the strobe to the last bit
  busy_when_active: assert property (
    @(posedge ssi_clk) disable iff (!rst_n)
    (state != adc_pkg::ST_IDLE) |-> busy
  ) else begin
    $error("busy was low while the deserializer was not idle");
    fail_count++;
  end

  // A strobe in the middle of a word must not restart the latency wait
  cnv_ignored_when_busy: assert property (
    @(posedge ssi_clk) disable iff (!rst_n)
    (cnv && busy && state == adc_pkg::ST_SHIFT) |=> (state != adc_pkg::ST_WAIT)
  ) else begin
    $error("cnv during a conversion restarted the deserializer");
    fail_count++;
  end

endmodule

// ==== test/adc_capture_tb.sv ====
// ADC capture testbench

`timescale 1ns/100ps

module adc_capture_tb;

  localparam int unsigned FIFO_DEPTH = 8;
  localparam int unsigned W          = adc_pkg::SAMPLE_WIDTH;
  localparam int unsigned AW         = adc_pkg::REG_ADDR_WIDTH;
  // Cycle budget per trace line covers the longest latency, four words and slack
  localparam int unsigned LINE_CYCLES = 15 + 4 * 20 + 20;

  typedef struct {
    string        name;
    int           lanes;
    bit           uncor;
    int           latency;
    logic [W-1:0] sample;
    bit           ready;
  } trace_line_t;

  logic          ssi_clk;
  logic          rst_n;
  logic          cnv;
  logic          da;
  logic          db;
  logic [AW-1:0] awaddr;
  logic          awvalid;
  logic          awready;
  logic [31:0]   wdata;
  logic [3:0]    wstrb;
  logic          wvalid;
  logic          wready;
  logic [1:0]    bresp;
  logic          bvalid;
  logic          bready;
  logic [AW-1:0] araddr;
  logic          arvalid;
  logic          arready;
  logic [31:0]   rdata;
  logic [1:0]    rresp;
  logic          rvalid;
  logic          rready;
  logic [W-1:0]  s_data;
  logic          s_valid;
  logic          s_ready;

  trace_line_t   trace[$];
  // Samples that should be sitting in the FIFO under back-pressure
  logic [W-1:0]  backlog[$];
  logic [31:0]   rng;
  int            expected_count;
  bit            ovf_expected;
  int            cycle_count;
  int            timeout_limit;

  clk_gen clk0 (.*);

  adc_capture_top #(.FIFO_DEPTH(FIFO_DEPTH)) dut0 (.*);

  bind lane_deserializer adc_capture_properties props0 (
    .ssi_clk    (ssi_clk),
    .rst_n      (rst_n),
    .cnv        (cnv),
    .word_valid (word_valid),
    .busy       (cfg.busy),
    .two_lane   (two_lane_q),
    .state      (state)
  );

  // ********************************************************************
  // Helpers
  // ********************************************************************

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("CHECK FAILED %s expected 0x%h actual 0x%h",
                                  name, expected, actual));
    end
  endtask

  // Every task starts and ends 1 ns after a rising edge
  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge ssi_clk);
      #1;
    end
  endtask

  // The run is bounded by a cycle budget taken from the trace length
  always @(posedge ssi_clk) begin
    cycle_count <= cycle_count + 1;
    if (timeout_limit != 0 && cycle_count >= timeout_limit) begin
      stop_with_failure($sformatf("Timeout after %0d cycles, the DUT stopped responding",
                                  cycle_count));
    end
  end

  // ********************************************************************
  // AXI4-Lite master
  // ********************************************************************

  task automatic reg_write(input logic [AW-1:0] addr, input logic [31:0] data);
    logic aw_hit;
    logic w_hit;
    logic b_hit;
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wstrb   = 4'hF;
    wvalid  = 1'b1;
    bready  = 1'b1;
    // AW and W complete on their own handshakes
    while (awvalid || wvalid) begin
      @(negedge ssi_clk);
      aw_hit = awvalid && awready;
      w_hit  = wvalid && wready;
      @(posedge ssi_clk);
      #1;
      if (aw_hit) awvalid = 1'b0;
      if (w_hit) wvalid = 1'b0;
    end
    b_hit = 1'b0;
    while (!b_hit) begin
      @(negedge ssi_clk);
      b_hit = bvalid;
      if (b_hit) check_value("write response", 32'd0, 32'(bresp));
      @(posedge ssi_clk);
      #1;
    end
    bready = 1'b0;
  endtask

  task automatic read_expect(input string name, input logic [AW-1:0] addr,
                             input logic [31:0] expected);
    logic        hit;
    logic [31:0] data;
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    hit     = 1'b0;
    while (!hit) begin
      @(negedge ssi_clk);
      hit = arready;
      @(posedge ssi_clk);
      #1;
    end
    arvalid = 1'b0;
    hit     = 1'b0;
    while (!hit) begin
      @(negedge ssi_clk);
      hit  = rvalid;
      data = rdata;
      if (hit) check_value({name, " response"}, 32'd0, 32'(rresp));
      @(posedge ssi_clk);
      #1;
    end
    rready = 1'b0;
    check_value(name, expected, data);
  endtask

  // ********************************************************************
  // Converter model and stream sink
  // ********************************************************************

  // Uncorrected mode sends all ones, the inverted sample, zeros, then the sample
  task automatic send_conversion(input int lanes, input bit uncor, input int latency,
                                 input logic [W-1:0] sample);
    logic [W-1:0] words[4];
    int           first;
    words[0] = '1;
    words[1] = ~sample;
    words[2] = '0;
    words[3] = sample;
    first    = uncor ? 0 : 3;
    cnv = 1'b1;
    @(posedge ssi_clk);
    #1;
    cnv = 1'b0;
    // The MSB must be on the lanes before edge latency
    idle_cycles(latency - 1);
    for (int w = first; w < 4; w++) begin
      for (int b = W - 1; b >= 0; b -= lanes) begin
        da = words[w][b];
        db = (lanes == 2) ? words[w][b-1] : 1'b0;
        // Stray strobe in the middle of the last word
        cnv = (w == 3) && (b == 11);
        idle_cycles(1);
      end
    end
    cnv = 1'b0;
    da  = 1'b0;
    db  = 1'b0;
  endtask

  task automatic wait_for_sample(input string name, input logic [W-1:0] expected,
                                 input bit random_ready);
    logic taken;
    taken = 1'b0;
    while (!taken) begin
      rng     = xorshift(rng);
      s_ready = random_ready ? rng[0] : 1'b1;
      @(negedge ssi_clk);
      taken = s_valid && s_ready;
      if (taken) check_value(name, 32'(expected), 32'(s_data));
      @(posedge ssi_clk);
      #1;
    end
    s_ready = 1'b0;
  endtask

  // ********************************************************************
  // Test steps
  // ********************************************************************

  task automatic load_trace();
    int          fd;
    string       line;
    trace_line_t t;
    int          uncor;
    int          ready;
    logic [31:0] sample;
    fd = $fopen("test/adc_trace.txt", "r");
    if (fd == 0) stop_with_failure("Cannot open the trace file test/adc_trace.txt");
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line[0] != "#") begin
        if ($sscanf(line, "%s %d %d %d %h %d", t.name, t.lanes, uncor, t.latency,
                    sample, ready) != 6) begin
          stop_with_failure({"Malformed trace line: ", line});
        end
        t.uncor  = (uncor != 0);
        t.ready  = (ready != 0);
        t.sample = sample[W-1:0];
        trace.push_back(t);
      end
    end
    $fclose(fd);
  endtask

  task automatic check_registers();
    read_expect("count after reset", adc_pkg::ADDR_COUNT, 32'd0);
    read_expect("status after reset", adc_pkg::ADDR_STATUS, 32'd0);
    read_expect("ctrl after reset", adc_pkg::ADDR_CTRL, 32'd0);
    reg_write(adc_pkg::ADDR_CTRL, 32'h6);
    read_expect("ctrl readback", adc_pkg::ADDR_CTRL, 32'h6);
    reg_write(adc_pkg::ADDR_LATENCY, 32'h9);
    read_expect("latency readback", adc_pkg::ADDR_LATENCY, 32'h9);
    // Address 0x2 sits between registers so writes vanish and reads give zero
    reg_write(AW'(2), 32'hFFFF_FFFF);
    read_expect("unmapped address", AW'(2), 32'd0);
    read_expect("ctrl after unmapped write", adc_pkg::ADDR_CTRL, 32'h6);
    read_expect("latency after unmapped write", adc_pkg::ADDR_LATENCY, 32'h9);
  endtask

  // Releases s_ready and expects the held samples in order, then clears overflow
  task automatic drain_backlog();
    read_expect("backlog count", adc_pkg::ADDR_COUNT, 32'(expected_count));
    read_expect("overflow status", adc_pkg::ADDR_STATUS, {31'd0, ovf_expected});
    while (backlog.size() != 0) begin
      wait_for_sample("backlog drain", backlog.pop_front(), 1'b0);
    end
    s_ready = 1'b1;
    @(negedge ssi_clk);
    check_value("fifo empty after drain", 32'd0, 32'(s_valid));
    idle_cycles(1);
    s_ready = 1'b0;
    reg_write(adc_pkg::ADDR_STATUS, 32'h1);
    read_expect("overflow cleared", adc_pkg::ADDR_STATUS, 32'd0);
    ovf_expected = 1'b0;
  endtask

  task automatic run_trace_line(input trace_line_t t);
    if (t.ready && backlog.size() != 0) drain_backlog();
    reg_write(adc_pkg::ADDR_CTRL, {29'd0, t.uncor, t.lanes == 2, 1'b1});
    reg_write(adc_pkg::ADDR_LATENCY, 32'(t.latency));
    s_ready = 1'b0;
    send_conversion(t.lanes, t.uncor, t.latency, t.sample);
    if (t.ready) begin
      wait_for_sample(t.name, t.sample, 1'b1);
      expected_count++;
      read_expect({t.name, " count"}, adc_pkg::ADDR_COUNT, 32'(expected_count));
    end else begin
      // Nothing leaves the FIFO, so a word takes a free slot or is dropped
      if (backlog.size() < FIFO_DEPTH) begin
        backlog.push_back(t.sample);
        expected_count++;
      end else begin
        ovf_expected = 1'b1;
      end
      idle_cycles(2);
    end
  endtask

  // With enable cleared the strobes are ignored and nothing reaches the stream
  task automatic check_disabled();
    reg_write(adc_pkg::ADDR_CTRL, 32'h0);
    reg_write(adc_pkg::ADDR_LATENCY, 32'h2);
    repeat (3) begin
      rng = xorshift(rng);
      send_conversion(1, 1'b0, 2, rng[W-1:0]);
    end
    s_ready = 1'b1;
    repeat (4) begin
      @(negedge ssi_clk);
      check_value("disabled output", 32'd0, 32'(s_valid));
      idle_cycles(1);
    end
    s_ready = 1'b0;
    read_expect("disabled count", adc_pkg::ADDR_COUNT, 32'(expected_count));
    read_expect("disabled status", adc_pkg::ADDR_STATUS, 32'd0);
  endtask

  // ********************************************************************
  // Main sequence
  // ********************************************************************

  initial begin
    cnv            = 1'b0;
    da             = 1'b0;
    db             = 1'b0;
    awaddr         = '0;
    awvalid        = 1'b0;
    wdata          = 32'd0;
    wstrb          = 4'h0;
    wvalid         = 1'b0;
    bready         = 1'b0;
    araddr         = '0;
    arvalid        = 1'b0;
    rready         = 1'b0;
    s_ready        = 1'b0;
    rng            = 32'h0954_abd6;
    expected_count = 0;
    ovf_expected   = 1'b0;
    cycle_count    = 0;
    timeout_limit  = 0;
    load_trace();
    timeout_limit = trace.size() * LINE_CYCLES + 200;
    wait (rst_n === 1'b1);
    idle_cycles(1);
    check_registers();
    foreach (trace[i]) begin
      run_trace_line(trace[i]);
    end
    if (backlog.size() != 0) drain_backlog();
    check_disabled();
    if (dut0.deser0.props0.fail_count != 0) begin
      stop_with_failure("Concurrent assertions on the deserializer failed");
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

// ==== test/adc_trace.txt ====
# name lanes uncorrected latency sample_hex ready
# ready 1 toggles s_ready from xorshift, ready 0 holds s_ready low for back-pressure
one_lat1 1 0 1 a5c3f 1
one_lat3 1 0 3 00001 1
one_lat7 1 0 7 80000 1
one_lat15 1 0 15 3b7e2 1
two_lat1 2 0 1 12345 1
two_lat5 2 0 5 fffff 1
uncor_one 1 1 2 3c96e 1
uncor_two 2 1 4 c3a17 1
bp_00 2 0 1 10001 0
bp_01 2 0 1 20002 0
bp_02 2 0 1 30003 0
bp_03 2 0 1 40004 0
bp_04 2 0 1 50005 0
bp_05 2 0 1 60006 0
bp_06 2 0 1 70007 0
bp_07 2 0 1 80008 0
bp_08 2 0 1 90009 0
bp_09 2 0 1 a000a 0

// ==== test/clk_gen.sv ====
// Testbench clock and reset

`timescale 1ns/100ps

module clk_gen (
  output logic ssi_clk,
  output logic rst_n
);

  // 100 ns period
  initial begin
    ssi_clk = 1'b0;
    forever #50 ssi_clk = ~ssi_clk;
  end

  // Reset is held for ten rising edges and released just after the last one
  initial begin
    rst_n = 1'b0;
    repeat (10) @(posedge ssi_clk);
    #1 rst_n = 1'b1;
  end

endmodule

// ==== verilog.f ====
verilog/adc_pkg.sv
verilog/capture_cfg_if.sv
verilog/adc_regs.sv
verilog/lane_deserializer.sv
verilog/sample_fifo.sv
verilog/adc_capture_top.sv
test/clk_gen.sv
test/adc_capture_properties.sv
test/adc_capture_tb.sv

// ==== verilog/adc_capture_top.sv ====
// ADC serial capture top level

`timescale 1ns/100ps

module adc_capture_top #(
  parameter int unsigned FIFO_DEPTH = 8
) (
  input  logic                               ssi_clk,
  input  logic                               rst_n,
  // Converter interface
  input  logic                               cnv,
  input  logic                               da,
  input  logic                               db,
  // AXI4-Lite slave
  input  logic [adc_pkg::REG_ADDR_WIDTH-1:0] awaddr,
  input  logic                               awvalid,
  output logic                               awready,
  input  logic [31:0]                        wdata,
  input  logic [3:0]                         wstrb,
  input  logic                               wvalid,
  output logic                               wready,
  output logic [1:0]                         bresp,
  output logic                               bvalid,
  input  logic                               bready,
  input  logic [adc_pkg::REG_ADDR_WIDTH-1:0] araddr,
  input  logic                               arvalid,
  output logic                               arready,
  output logic [31:0]                        rdata,
  output logic [1:0]                         rresp,
  output logic                               rvalid,
  input  logic                               rready,
  // Sample stream
  output logic [adc_pkg::SAMPLE_WIDTH-1:0]   s_data,
  output logic                               s_valid,
  input  logic                               s_ready
);

  logic [adc_pkg::SAMPLE_WIDTH-1:0] word_data;
  logic                             word_valid;
  logic                             accepted;
  logic                             overflow;

  // Configuration from the registers to the deserializer
  capture_cfg_if cfg0 ();

  adc_regs regs0 (
    .ssi_clk (ssi_clk),  .rst_n   (rst_n),
    .awaddr  (awaddr),   .awvalid (awvalid), .awready (awready),
    .wdata   (wdata),    .wstrb   (wstrb),   .wvalid  (wvalid),  .wready (wready),
    .bresp   (bresp),    .bvalid  (bvalid),  .bready  (bready),
    .araddr  (araddr),   .arvalid (arvalid), .arready (arready),
    .rdata   (rdata),    .rresp   (rresp),   .rvalid  (rvalid),  .rready (rready),
    .overflow (overflow), .accepted (accepted),
    .cfg     (cfg0.regs)
  );

  lane_deserializer deser0 (
    .ssi_clk    (ssi_clk),   .rst_n      (rst_n),
    .cnv        (cnv),       .da         (da),        .db (db),
    .word_data  (word_data), .word_valid (word_valid),
    .cfg        (cfg0.capture)
  );

  // Depth is set here and passed down
  sample_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo0 (
    .ssi_clk    (ssi_clk),   .rst_n      (rst_n),
    .word_data  (word_data), .word_valid (word_valid), .s_ready (s_ready),
    .s_data     (s_data),    .s_valid    (s_valid),
    .accepted   (accepted),  .overflow   (overflow)
  );

endmodule

// ==== verilog/adc_pkg.sv ====
// ADC capture shared definitions

package adc_pkg;

  // ********************************************************************
  // Converter word format
  // ********************************************************************

  // Bits in one converter word, shifted out MSB first
  localparam int unsigned SAMPLE_WIDTH = 20;

  // Words per conversion in uncorrected mode, of which the last is the sample
  localparam int unsigned UNCOR_WORDS = 4;

  // ********************************************************************
  // Register map, one 32-bit word per register
  // ********************************************************************

  localparam int unsigned REG_ADDR_WIDTH = 4;

  // Bit 0 enable, bit 1 two_lane, bit 2 uncorrected
  localparam logic [REG_ADDR_WIDTH-1:0] ADDR_CTRL    = 4'h0;
  // Bits 3..0 hold the latency in ssi_clk cycles
  localparam logic [REG_ADDR_WIDTH-1:0] ADDR_LATENCY = 4'h4;
  // Read-only count of samples accepted into the FIFO
  localparam logic [REG_ADDR_WIDTH-1:0] ADDR_COUNT   = 4'h8;
  // Bit 0 sticky overflow (write 1 to clear), bit 1 busy
  localparam logic [REG_ADDR_WIDTH-1:0] ADDR_STATUS  = 4'hC;

  // ********************************************************************
  // Enumerations
  // ********************************************************************

  // Deserializer FSM states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT,
    ST_SHIFT
  } capture_state_e;

  // Lane mode sets the number of bits taken per clock edge
  typedef enum logic {
    LANE_ONE,
    LANE_TWO
  } lane_mode_e;

endpackage

// ==== verilog/adc_regs.sv ====
// AXI4-Lite control registers

`timescale 1ns/100ps

module adc_regs (
  input  logic                               ssi_clk,
  input  logic                               rst_n,
  // AXI4-Lite write address and data
  input  logic [adc_pkg::REG_ADDR_WIDTH-1:0] awaddr,
  input  logic                               awvalid,
  output logic                               awready,
  input  logic [31:0]                        wdata,
  input  logic [3:0]                         wstrb,
  input  logic                               wvalid,
  output logic                               wready,
  // AXI4-Lite write response
  output logic [1:0]                         bresp,
  output logic                               bvalid,
  input  logic                               bready,
  // AXI4-Lite read
  input  logic [adc_pkg::REG_ADDR_WIDTH-1:0] araddr,
  input  logic                               arvalid,
  output logic                               arready,
  output logic [31:0]                        rdata,
  output logic [1:0]                         rresp,
  output logic                               rvalid,
  input  logic                               rready,
  // Events from the FIFO
  input  logic                               overflow,
  input  logic                               accepted,
  capture_cfg_if.regs                        cfg
);

  // Latched write address and data, held until the response is raised
  logic [adc_pkg::REG_ADDR_WIDTH-1:0] aw_addr_q;
  logic [31:0]                        w_data_q;
  logic [3:0]                         w_strb_q;
  logic                               aw_hold;
  logic                               w_hold;
  // One-cycle strobe that commits the latched write
  logic                               wr_pulse;
  logic                               wr_byte0;
  logic [31:0]                        sample_count;
  logic                               ovf_sticky;

  // All accesses complete without error
  assign bresp = 2'b00;
  assign rresp = 2'b00;

  // Only byte 0 carries writable bits in this map
  assign wr_byte0 = wr_pulse && w_strb_q[0];

  // ********************************************************************
  // Write channels
  // ********************************************************************

  always_ff @(posedge ssi_clk) begin
    if (!rst_n) begin
      awready  <= 1'b0;
      wready   <= 1'b0;
      bvalid   <= 1'b0;
      aw_hold  <= 1'b0;
      w_hold   <= 1'b0;
      wr_pulse <= 1'b0;
    end else begin
      wr_pulse <= 1'b0;
      // AW is taken on its own handshake and then held off
      if (awvalid && awready) begin
        aw_addr_q <= awaddr;
        aw_hold   <= 1'b1;
        awready   <= 1'b0;
      end else if (!aw_hold && !bvalid) begin
        awready <= 1'b1;
      end
      // W follows the same pattern independently of AW
      if (wvalid && wready) begin
        w_data_q <= wdata;
        w_strb_q <= wstrb;
        w_hold   <= 1'b1;
        wready   <= 1'b0;
      end else if (!w_hold && !bvalid) begin
        wready <= 1'b1;
      end
      // Both halves present, so respond and commit on the next edge
      if (aw_hold && w_hold && !bvalid) begin
        bvalid   <= 1'b1;
        aw_hold  <= 1'b0;
        w_hold   <= 1'b0;
        wr_pulse <= 1'b1;
      end else if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  // ********************************************************************
  // Register storage
  // ********************************************************************

  always_ff @(posedge ssi_clk) begin
    if (!rst_n) begin
      cfg.enable      <= 1'b0;
      cfg.lane_mode   <= adc_pkg::LANE_ONE;
      cfg.uncorrected <= 1'b0;
      cfg.latency     <= 4'd0;
      sample_count    <= 32'd0;
      ovf_sticky      <= 1'b0;
    end else begin
      if (wr_byte0 && aw_addr_q == adc_pkg::ADDR_CTRL) begin
        cfg.enable      <= w_data_q[0];
        cfg.lane_mode   <= w_data_q[1] ? adc_pkg::LANE_TWO : adc_pkg::LANE_ONE;
        cfg.uncorrected <= w_data_q[2];
      end
      if (wr_byte0 && aw_addr_q == adc_pkg::ADDR_LATENCY) begin
        cfg.latency <= w_data_q[3:0];
      end
      if (accepted) begin
        sample_count <= sample_count + 32'd1;
      end
      // A new overflow wins over a clear in the same cycle
      if (overflow) begin
        ovf_sticky <= 1'b1;
      end else if (wr_byte0 && aw_addr_q == adc_pkg::ADDR_STATUS && w_data_q[0]) begin
        ovf_sticky <= 1'b0;
      end
    end
  end

  // ********************************************************************
  // Read channel
  // ********************************************************************

  always_ff @(posedge ssi_clk) begin
    if (!rst_n) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else if (arvalid && arready) begin
      arready <= 1'b0;
      rvalid  <= 1'b1;
      case (araddr)
        adc_pkg::ADDR_CTRL:
          rdata <= {29'd0, cfg.uncorrected, cfg.lane_mode == adc_pkg::LANE_TWO, cfg.enable};
        adc_pkg::ADDR_LATENCY: rdata <= {28'd0, cfg.latency};
        adc_pkg::ADDR_COUNT:   rdata <= sample_count;
        adc_pkg::ADDR_STATUS:  rdata <= {30'd0, cfg.busy, ovf_sticky};
        default:               rdata <= 32'd0;
      endcase
    end else if (rvalid && rready) begin
      rvalid  <= 1'b0;
      arready <= 1'b1;
    end else if (!rvalid) begin
      arready <= 1'b1;
    end
  end

endmodule

// ==== verilog/capture_cfg_if.sv ====
// Capture configuration interface

`timescale 1ns/100ps

interface capture_cfg_if;

  // Capture is armed only while enable is set
  logic                enable;
  // One lane takes a bit per edge, two lanes take two
  adc_pkg::lane_mode_e lane_mode;
  // Converter sends four words per conversion when set
  logic                uncorrected;
  // Cycles from the cnv edge to the MSB edge
  logic [3:0]          latency;
  // High while a conversion is being received
  logic                busy;

  // Register block side
  modport regs (
    output enable,
    output lane_mode,
    output uncorrected,
    output latency,
    input  busy
  );

  // Deserializer side
  modport capture (
    input  enable,
    input  lane_mode,
    input  uncorrected,
    input  latency,
    output busy
  );

endinterface

// ==== verilog/lane_deserializer.sv ====
// Serial lane deserializer

`timescale 1ns/100ps

module lane_deserializer (
  input  logic                             ssi_clk,
  input  logic                             rst_n,
  input  logic                             cnv,
  input  logic                             da,
  input  logic                             db,
  output logic [adc_pkg::SAMPLE_WIDTH-1:0] word_data,
  output logic                             word_valid,
  capture_cfg_if.capture                   cfg
);

  localparam int unsigned W      = adc_pkg::SAMPLE_WIDTH;
  localparam int unsigned BCNT_W = $clog2(W + 1);
  localparam int unsigned WCNT_W = $clog2(adc_pkg::UNCOR_WORDS);

  adc_pkg::capture_state_e state;
  logic [3:0]              lat_cnt;
  logic [BCNT_W-1:0]       bit_cnt;
  logic [WCNT_W-1:0]       word_cnt;
  logic [W-1:0]            shift_reg;
  logic [W-1:0]            shift_next;
  // Mode captured at the strobe so a conversion is never split
  logic                    two_lane_q;
  logic                    uncor_q;
  logic                    word_done;
  logic                    last_word;

  // da carries the higher bit of each pair in two-lane mode
  assign shift_next = two_lane_q ? {shift_reg[W-3:0], da, db} : {shift_reg[W-2:0], da};

  // Last bit of the current word is on the lanes at this edge
  assign word_done = two_lane_q ? (bit_cnt == BCNT_W'(W - 2)) : (bit_cnt == BCNT_W'(W - 1));
  assign last_word = !uncor_q || (word_cnt == WCNT_W'(adc_pkg::UNCOR_WORDS - 1));

  always_ff @(posedge ssi_clk) begin
    if (!rst_n) begin
      state      <= adc_pkg::ST_IDLE;
      cfg.busy   <= 1'b0;
      word_valid <= 1'b0;
      lat_cnt    <= 4'd0;
      bit_cnt    <= '0;
      word_cnt   <= '0;
      two_lane_q <= 1'b0;
      uncor_q    <= 1'b0;
    end else begin
      word_valid <= 1'b0;
      case (state)
        adc_pkg::ST_IDLE: begin
          // This is edge 0 and the MSB follows at edge latency
          if (cnv && cfg.enable) begin
            cfg.busy   <= 1'b1;
            two_lane_q <= (cfg.lane_mode == adc_pkg::LANE_TWO);
            uncor_q    <= cfg.uncorrected;
            lat_cnt    <= cfg.latency - 4'd1;
            bit_cnt    <= '0;
            word_cnt   <= '0;
            // A latency of 0 or 1 starts sampling on the very next edge
            state      <= (cfg.latency <= 4'd1) ? adc_pkg::ST_SHIFT : adc_pkg::ST_WAIT;
          end
        end
        adc_pkg::ST_WAIT: begin
          lat_cnt <= lat_cnt - 4'd1;
          if (lat_cnt == 4'd1) begin
            state <= adc_pkg::ST_SHIFT;
          end
        end
        adc_pkg::ST_SHIFT: begin
          bit_cnt <= bit_cnt + (two_lane_q ? BCNT_W'(2) : BCNT_W'(1));
          if (word_done) begin
            bit_cnt  <= '0;
            word_cnt <= word_cnt + 1'b1;
            // Uncorrected words run back to back with no gap
            if (last_word) begin
              word_valid <= 1'b1;
              cfg.busy   <= 1'b0;
              state      <= adc_pkg::ST_IDLE;
            end
          end
        end
        default: state <= adc_pkg::ST_IDLE;
      endcase
    end
  end

  // Shift register and the captured output word
  always_ff @(posedge ssi_clk) begin
    if (state == adc_pkg::ST_SHIFT) begin
      shift_reg <= shift_next;
      if (word_done && last_word) begin
        word_data <= shift_next;
      end
    end
  end

endmodule

// ==== verilog/sample_fifo.sv ====
// Sample FIFO with stream output

`timescale 1ns/100ps

module sample_fifo #(
  parameter int unsigned FIFO_DEPTH = 8
) (
  input  logic                             ssi_clk,
  input  logic                             rst_n,
  input  logic [adc_pkg::SAMPLE_WIDTH-1:0] word_data,
  input  logic                             word_valid,
  input  logic                             s_ready,
  output logic [adc_pkg::SAMPLE_WIDTH-1:0] s_data,
  output logic                             s_valid,
  output logic                             accepted,
  output logic                             overflow
);

  localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);

  logic [adc_pkg::SAMPLE_WIDTH-1:0] mem [FIFO_DEPTH];
  logic [PTR_W-1:0]                 wr_ptr;
  logic [PTR_W-1:0]                 rd_ptr;
  // One bit wider than the pointers so a full buffer is distinct from empty
  logic [PTR_W:0]                   count;
  logic                             full;
  logic                             push;
  logic                             pop;

  assign full = (count == (PTR_W + 1)'(FIFO_DEPTH));

  // The deserializer has no ready, so a word seen while full is lost
  assign push     = word_valid && !full;
  assign overflow = word_valid && full;
  assign accepted = push;

  // Head word stays on s_data until the consumer takes it
  assign s_valid = (count != '0);
  assign s_data  = mem[rd_ptr];
  assign pop     = s_valid && s_ready;

  // ********************************************************************
  // Pointers and occupancy
  // ********************************************************************

  always_ff @(posedge ssi_clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage array
  always_ff @(posedge ssi_clk) begin
    if (push) begin
      mem[wr_ptr] <= word_data;
    end
  end

endmodule
